// ==== include/i3c_settings.svh ====
// Build-time sizes and SCL timing for the I3C controller, included by the package and the timer
`ifndef I3C_SETTINGS_SVH
`define I3C_SETTINGS_SVH

// Number of device address table entries
`define I3C_DAT_DEPTH 16

// Host command word width
`define I3C_CMD_WIDTH 16

// System clock cycles per SCL half period
`define I3C_SCL_HALF_PERIOD 4

`endif

// ==== logic/i3c_pkg.sv ====
// Shared command, DAT entry, memory port, frame and response types of the I3C controller
`include "i3c_settings.svh"

package i3c_pkg;

  // Index into the device address table
  typedef logic [$clog2(`I3C_DAT_DEPTH)-1:0] dat_idx_t;

  // Bits left over after opcode, index and one byte
  typedef logic [`I3C_CMD_WIDTH-$bits(dat_idx_t)-10:0] cmd_pad_t;

  typedef enum logic {
    DAT_WRITE  = 1'b0,
    PRIV_WRITE = 1'b1
  } opcode_e;

  typedef struct packed {
    logic       valid;
    logic [6:0] dyn_addr;
  } dat_entry_t;

  typedef struct packed {
    opcode_e    opcode;
    dat_idx_t   idx;
    dat_entry_t entry;
    cmd_pad_t   pad;
  } dat_write_cmd_t;

  typedef struct packed {
    opcode_e    opcode;
    dat_idx_t   idx;
    logic [7:0] data;
    cmd_pad_t   pad;
  } priv_write_cmd_t;

  // Opcode sits in the MSB of both views
  typedef union packed {
    dat_write_cmd_t  dat_wr;
    priv_write_cmd_t priv_wr;
  } cmd_u;

  typedef struct packed {
    logic       req;
    logic       write;
    dat_idx_t   addr;
    dat_entry_t wdata;
  } dat_mem_sink_t;

  typedef struct packed {
    dat_entry_t rdata;
  } dat_mem_src_t;

  typedef struct packed {
    logic [6:0] dyn_addr;
    logic [7:0] data;
  } frame_t;

  typedef enum logic [1:0] {
    STATUS_OK      = 2'd0,
    STATUS_NACK    = 2'd1,
    STATUS_INVALID = 2'd2
  } status_e;

  typedef struct packed {
    status_e  status;
    dat_idx_t idx;
  } rsp_t;

endpackage

// ==== logic/i3c_dat_mem.sv ====
// Single-port device address table with a registered read, driven by the controller FSM
module i3c_dat_mem (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  i3c_pkg::dat_mem_sink_t mem_sink_i,
  output i3c_pkg::dat_mem_src_t  mem_src_o
);

  i3c_pkg::dat_entry_t mem_q [2**$bits(i3c_pkg::dat_idx_t)];
  i3c_pkg::dat_entry_t rdata_q;

  // Only the valid bits are cleared, addresses stay as they were
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 2**$bits(i3c_pkg::dat_idx_t); i++) begin
        mem_q[i].valid <= 1'b0;
      end
    end else if (mem_sink_i.req && mem_sink_i.write) begin
      mem_q[mem_sink_i.addr] <= mem_sink_i.wdata;
    end
  end

  // Read data shows up the cycle after the request
  always_ff @(posedge clk_i) begin
    if (mem_sink_i.req && !mem_sink_i.write) begin
      rdata_q <= mem_q[mem_sink_i.addr];
    end
  end

  assign mem_src_o.rdata = rdata_q;

endmodule

// ==== logic/i3c_scl_timer.sv ====
// Half-period tick source that paces the SCL/SDA bit shifter while a transfer runs
`include "i3c_settings.svh"

module i3c_scl_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic enable_i,
  output logic tick_o
);

  localparam int unsigned cnt_width = $clog2(`I3C_SCL_HALF_PERIOD + 1);
  localparam logic [cnt_width-1:0] reload_val = cnt_width'(`I3C_SCL_HALF_PERIOD - 1);

  logic [cnt_width-1:0] count_q;

  // Tick on the cycle the counter reaches zero
  assign tick_o = enable_i && (count_q == '0);

  // Held at the reload value while disabled, so the first
  // tick comes a whole half period after enable rises
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= reload_val;
    end else if (!enable_i) begin
      count_q <= reload_val;
    end else if (tick_o) begin
      count_q <= reload_val;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

endmodule

// ==== logic/i3c_bit_shifter.sv ====
// Drives START, address, ACK slot, data with T bit and STOP onto SCL/SDA, stepped by timer ticks
module i3c_bit_shifter (
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic            start_i,
  input  i3c_pkg::frame_t frame_i,
  input  logic            tick_i,
  input  logic            sda_i,
  output logic            done_o,
  output logic            nack_o,
  output logic            scl_o,
  output logic            sda_o,
  output logic            sel_od_pp_o
);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_START,
    PH_ADDR,
    PH_ACK,
    PH_DATA,
    PH_STOP
  } phase_e;

  phase_e      phase_q;
  logic        high_q;
  logic        settle_q;
  logic [3:0]  bit_cnt_q;
  logic [16:0] shift_q;
  logic        scl_q;
  logic        sda_q;
  logic        sel_q;
  logic        done_q;
  logic        nack_q;
  logic        sda_next;

  // SDA level for the low half just entered
  always_comb begin
    case (phase_q)
      PH_ADDR, PH_DATA: sda_next = shift_q[16];
      PH_STOP:          sda_next = 1'b0;
      default:          sda_next = 1'b1;
    endcase
  end

  // Address byte with write bit, then data byte and odd parity
  always_ff @(posedge clk_i) begin
    if (phase_q == PH_IDLE && start_i) begin
      shift_q <= {frame_i.dyn_addr, 1'b0, frame_i.data, ~^frame_i.data};
    end else if (tick_i && high_q && (phase_q == PH_ADDR || phase_q == PH_DATA)) begin
      shift_q <= {shift_q[15:0], 1'b0};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q   <= PH_IDLE;
      high_q    <= 1'b0;
      settle_q  <= 1'b0;
      bit_cnt_q <= '0;
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
      sel_q     <= 1'b0;
      done_q    <= 1'b0;
      nack_q    <= 1'b0;
    end else begin
      done_q   <= 1'b0;
      settle_q <= 1'b0;
      // SDA and the drive mode move one cycle after SCL has fallen
      if (settle_q) begin
        sda_q <= sda_next;
        sel_q <= (phase_q == PH_DATA);
      end
      if (phase_q == PH_IDLE) begin
        if (start_i) begin
          phase_q <= PH_START;
          sda_q   <= 1'b0;
          nack_q  <= 1'b0;
        end
      end else if (tick_i) begin
        if (phase_q == PH_START) begin
          phase_q   <= PH_ADDR;
          bit_cnt_q <= '0;
          scl_q     <= 1'b0;
          high_q    <= 1'b0;
          settle_q  <= 1'b1;
        end else if (!high_q) begin
          scl_q  <= 1'b1;
          high_q <= 1'b1;
        end else if (phase_q == PH_STOP) begin
          // SDA rises with SCL high
          sda_q   <= 1'b1;
          high_q  <= 1'b0;
          phase_q <= PH_IDLE;
          done_q  <= 1'b1;
        end else begin
          scl_q     <= 1'b0;
          high_q    <= 1'b0;
          settle_q  <= 1'b1;
          bit_cnt_q <= bit_cnt_q + 4'd1;
          case (phase_q)
            PH_ADDR: begin
              if (bit_cnt_q == 4'd7) begin
                phase_q <= PH_ACK;
              end
            end
            PH_ACK: begin
              // Target holds SDA low to acknowledge
              nack_q    <= sda_i;
              bit_cnt_q <= '0;
              phase_q   <= sda_i ? PH_STOP : PH_DATA;
            end
            default: begin
              if (bit_cnt_q == 4'd8) begin
                phase_q <= PH_STOP;
              end
            end
          endcase
        end
      end
    end
  end

  assign scl_o       = scl_q;
  assign sda_o       = sda_q;
  assign sel_od_pp_o = sel_q;
  assign done_o      = done_q;
  assign nack_o      = nack_q;

endmodule

// ==== logic/i3c_ctrl_fsm.sv ====
// Controller FSM that takes host commands, works the DAT, runs bus transfers and answers
module i3c_ctrl_fsm (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   cmd_valid_i,
  input  i3c_pkg::cmd_u          cmd_i,
  input  logic                   rsp_ready_i,
  input  i3c_pkg::dat_mem_src_t  mem_src_i,
  input  logic                   shift_done_i,
  input  logic                   shift_nack_i,
  output logic                   cmd_ready_o,
  output logic                   rsp_valid_o,
  output i3c_pkg::rsp_t          rsp_o,
  output i3c_pkg::dat_mem_sink_t mem_sink_o,
  output logic                   timer_en_o,
  output logic                   shift_start_o,
  output i3c_pkg::frame_t        frame_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DAT_ACCESS,
    ST_CHECK,
    ST_XFER,
    ST_RESP
  } state_e;

  state_e            state_q;
  i3c_pkg::cmd_u     cmd_q;
  i3c_pkg::status_e  status_q;
  logic              is_dat_write;
  logic              is_priv_write;

  // Opcode is in the same place in both views of the word
  assign is_dat_write  = (cmd_q.dat_wr.opcode == i3c_pkg::DAT_WRITE);
  assign is_priv_write = (cmd_q.priv_wr.opcode == i3c_pkg::PRIV_WRITE);

  assign cmd_ready_o = (state_q == ST_IDLE);
  assign rsp_valid_o = (state_q == ST_RESP);
  assign rsp_o.status = status_q;
  assign rsp_o.idx    = cmd_q.dat_wr.idx;

  // One DAT access per command, write or read
  always_comb begin
    mem_sink_o = '0;
    if (state_q == ST_DAT_ACCESS) begin
      mem_sink_o.req   = 1'b1;
      mem_sink_o.write = is_dat_write;
      mem_sink_o.addr  = cmd_q.dat_wr.idx;
      mem_sink_o.wdata = cmd_q.dat_wr.entry;
    end
  end

  // Entry read data is valid while in CHECK
  assign frame_o.dyn_addr = mem_src_i.rdata.dyn_addr;
  assign frame_o.data     = cmd_q.priv_wr.data;
  assign shift_start_o    = (state_q == ST_CHECK) && mem_src_i.rdata.valid;
  assign timer_en_o       = (state_q == ST_XFER);

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= ST_IDLE;
      status_q <= i3c_pkg::STATUS_OK;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (cmd_valid_i) begin
            state_q <= ST_DAT_ACCESS;
          end
        end
        ST_DAT_ACCESS: begin
          if (is_priv_write) begin
            state_q <= ST_CHECK;
          end else begin
            status_q <= i3c_pkg::STATUS_OK;
            state_q  <= ST_RESP;
          end
        end
        ST_CHECK: begin
          if (mem_src_i.rdata.valid) begin
            state_q <= ST_XFER;
          end else begin
            status_q <= i3c_pkg::STATUS_INVALID;
            state_q  <= ST_RESP;
          end
        end
        ST_XFER: begin
          if (shift_done_i) begin
            status_q <= shift_nack_i ? i3c_pkg::STATUS_NACK : i3c_pkg::STATUS_OK;
            state_q  <= ST_RESP;
          end
        end
        ST_RESP: begin
          // Response holds until the host takes it
          if (rsp_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/i3c_wrapper.sv ====
// Top level of the I3C controller subsystem, joining FSM, SCL timer, bit shifter and DAT memory
module i3c_wrapper (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          cmd_valid_i,
  input  i3c_pkg::cmd_u cmd_i,
  input  logic          rsp_ready_i,
  input  logic          sda_i,
  output logic          cmd_ready_o,
  output logic          rsp_valid_o,
  output i3c_pkg::rsp_t rsp_o,
  output logic          scl_o,
  output logic          sda_o,
  output logic          sel_od_pp_o
);

  // DAT memory port
  i3c_pkg::dat_mem_sink_t dat_mem_sink;
  i3c_pkg::dat_mem_src_t  dat_mem_src;

  logic            timer_en;
  logic            tick;
  logic            shift_start;
  logic            shift_done;
  logic            shift_nack;
  i3c_pkg::frame_t frame;

  i3c_ctrl_fsm ctrl_fsm (
    .clk_i,
    .reset_i,
    .cmd_valid_i,
    .cmd_i,
    .rsp_ready_i,
    .mem_src_i    (dat_mem_src),
    .shift_done_i (shift_done),
    .shift_nack_i (shift_nack),
    .cmd_ready_o,
    .rsp_valid_o,
    .rsp_o,
    .mem_sink_o   (dat_mem_sink),
    .timer_en_o   (timer_en),
    .shift_start_o(shift_start),
    .frame_o      (frame)
  );

  i3c_scl_timer scl_timer (
    .clk_i,
    .reset_i,
    .enable_i(timer_en),
    .tick_o  (tick)
  );

  i3c_bit_shifter bit_shifter (
    .clk_i,
    .reset_i,
    .start_i(shift_start),
    .frame_i(frame),
    .tick_i (tick),
    .sda_i,
    .done_o (shift_done),
    .nack_o (shift_nack),
    .scl_o,
    .sda_o,
    .sel_od_pp_o
  );

  i3c_dat_mem dat_memory (
    .clk_i,
    .reset_i,
    .mem_sink_i(dat_mem_sink),
    .mem_src_o (dat_mem_src)
  );

endmodule

// ==== tb/i3c_wrapper_properties.sv ====
// Handshake and drive-mode assertions, bound into the I3C wrapper during simulation
module i3c_wrapper_properties (
  input logic          clk_i,
  input logic          reset_i,
  input logic          cmd_ready_i,
  input logic          rsp_valid_i,
  input logic          rsp_ready_i,
  input i3c_pkg::rsp_t rsp_i,
  input logic          sel_od_pp_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Response must hold until the host takes it
  rsp_held: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_i && !rsp_ready_i |=> $stable(rsp_i))
    else $error("rsp_o changed while rsp_ready_i was low");

  one_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
    !(cmd_ready_i && rsp_valid_i))
    else $error("cmd_ready_o and rsp_valid_o high together");

  // Push-pull drive only inside a transfer
  pp_only_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    !(sel_od_pp_i && cmd_ready_i))
    else $error("sel_od_pp_o high while idle");

endmodule

bind i3c_wrapper i3c_wrapper_properties wrapper_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .cmd_ready_i (cmd_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_i       (rsp_o),
  .sel_od_pp_i (sel_od_pp_o)
);

// ==== tb/i3c_wrapper_tb.sv ====
// Directed testbench for the I3C wrapper with a target bus model, used as the simulation top
`include "i3c_settings.svh"

module i3c_wrapper_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 5000;

  logic          clk_i;
  logic          reset_i;
  logic          cmd_valid_i;
  i3c_pkg::cmd_u cmd_i;
  logic          rsp_ready_i;
  logic          sda_i;
  logic          cmd_ready_o;
  logic          rsp_valid_o;
  i3c_pkg::rsp_t rsp_o;
  logic          scl_o;
  logic          sda_o;
  logic          sel_od_pp_o;

  // Target model state
  logic       ack_pull;
  logic       prev_scl;
  logic       prev_sda;
  logic       line_sda;
  logic [7:0] addr_byte;
  logic [8:0] data_bits;
  logic       ack_low;
  logic       sel_ok;
  int         rise_cnt;
  int         start_cnt;
  int         stop_cnt;
  int         cycle_cnt = 0;

  // Expected DAT contents
  logic       shadow_valid [`I3C_DAT_DEPTH];
  logic [6:0] shadow_addr [`I3C_DAT_DEPTH];

  // Open-drain line, the target only pulls low
  assign sda_i = sda_o & ~ack_pull;

  i3c_wrapper i3c_wrapper_i (
    .clk_i,
    .reset_i,
    .cmd_valid_i,
    .cmd_i,
    .rsp_ready_i,
    .sda_i,
    .cmd_ready_o,
    .rsp_valid_o,
    .rsp_o,
    .scl_o,
    .sda_o,
    .sel_od_pp_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      report_failure($sformatf("Timeout: tests did not finish within %0d cycles", cycle_cnt));
    end
  end

  // Target on the bus, sampled once outputs have settled
  always @(posedge clk_i) begin
    #10;
    line_sda = sda_i;
    if (!reset_i) begin
      if (scl_o && prev_scl && prev_sda && !line_sda) begin
        start_cnt++;
        rise_cnt  = 0;
        addr_byte = '0;
        data_bits = '0;
        ack_low   = 1'b0;
        sel_ok    = 1'b1;
      end
      if (scl_o && prev_scl && !prev_sda && line_sda) begin
        stop_cnt++;
      end
      if (scl_o && !prev_scl) begin
        // Push-pull only for the acknowledged data byte and T
        if (sel_od_pp_o != (ack_low && rise_cnt >= 9 && rise_cnt <= 17)) begin
          sel_ok = 1'b0;
        end
        if (rise_cnt < 8) begin
          addr_byte = {addr_byte[6:0], line_sda};
        end else if (rise_cnt == 8) begin
          ack_low = !line_sda;
        end else if (ack_low && rise_cnt <= 17) begin
          data_bits = {data_bits[7:0], line_sda};
        end
        rise_cnt++;
      end
      if (!scl_o && prev_scl) begin
        if (rise_cnt == 8 && responds(addr_byte[7:1])) begin
          ack_pull = 1'b1;
        end else if (rise_cnt == 9) begin
          ack_pull = 1'b0;
        end
      end
    end
    prev_scl = scl_o;
    prev_sda = line_sda;
  end

  function automatic logic responds(input logic [6:0] addr);
    return (addr == 7'h2A) || (addr == 7'h33) || (addr == 7'h4C);
  endfunction

  // T is set when the byte holds an even number of ones
  function automatic logic odd_parity(input logic [7:0] d);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (d[i]) begin
        ones++;
      end
    end
    return (ones % 2) == 0;
  endfunction

  function automatic i3c_pkg::cmd_u dat_cmd(input i3c_pkg::dat_idx_t idx, input logic [6:0] addr);
    i3c_pkg::cmd_u c;
    c = '0;
    c.dat_wr.opcode         = i3c_pkg::DAT_WRITE;
    c.dat_wr.idx            = idx;
    c.dat_wr.entry.valid    = 1'b1;
    c.dat_wr.entry.dyn_addr = addr;
    return c;
  endfunction

  function automatic i3c_pkg::cmd_u priv_cmd(input i3c_pkg::dat_idx_t idx, input logic [7:0] data);
    i3c_pkg::cmd_u c;
    c = '0;
    c.priv_wr.opcode = i3c_pkg::PRIV_WRITE;
    c.priv_wr.idx    = idx;
    c.priv_wr.data   = data;
    return c;
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_rsp(input string name, input i3c_pkg::rsp_t got,
                             input i3c_pkg::rsp_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_frame(input string name, input i3c_pkg::frame_t got,
                               input i3c_pkg::frame_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  // Latency counts the accepting edge as the first cycle
  task automatic send_cmd(input i3c_pkg::cmd_u c, output int lat);
    while (!cmd_ready_o) begin
      step();
    end
    cmd_valid_i = 1'b1;
    cmd_i       = c;
    step();
    cmd_valid_i = 1'b0;
    lat = 1;
    while (!rsp_valid_o) begin
      step();
      lat++;
    end
  endtask

  task automatic take_rsp(input int hold, output i3c_pkg::rsp_t r);
    r = rsp_o;
    if (hold > 0) begin
      rsp_ready_i = 1'b0;
      repeat (hold) begin
        step();
        compare_rsp("rsp_o", rsp_o, r);
        compare_bit("cmd_ready_o", cmd_ready_o, 1'b0);
        compare_bit("rsp_valid_o", rsp_valid_o, 1'b1);
      end
      rsp_ready_i = 1'b1;
    end
    step();
  endtask

  task automatic check_reset_state();
    compare_bit("cmd_ready_o", cmd_ready_o, 1'b1);
    compare_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    compare_bit("scl_o", scl_o, 1'b1);
    compare_bit("sda_o", sda_o, 1'b1);
    compare_bit("sel_od_pp_o", sel_od_pp_o, 1'b0);
  endtask

  task automatic write_entry(input i3c_pkg::dat_idx_t idx, input logic [6:0] addr);
    int            lat;
    i3c_pkg::rsp_t got;
    i3c_pkg::rsp_t exp;
    send_cmd(dat_cmd(idx, addr), lat);
    if (lat != 2) begin
      report_failure($sformatf("DAT write answered after %0d cycles instead of 2", lat));
    end
    take_rsp(0, got);
    exp.status = i3c_pkg::STATUS_OK;
    exp.idx    = idx;
    compare_rsp("rsp_o", got, exp);
    shadow_valid[idx] = 1'b1;
    shadow_addr[idx]  = addr;
  endtask

  task automatic private_write(input i3c_pkg::dat_idx_t idx, input logic [7:0] data,
                               input int hold);
    int              lat;
    int              starts;
    int              stops;
    i3c_pkg::rsp_t   got;
    i3c_pkg::rsp_t   exp;
    i3c_pkg::frame_t got_frame;
    i3c_pkg::frame_t exp_frame;
    starts = start_cnt;
    stops  = stop_cnt;
    if (!shadow_valid[idx]) begin
      exp.status = i3c_pkg::STATUS_INVALID;
    end else if (responds(shadow_addr[idx])) begin
      exp.status = i3c_pkg::STATUS_OK;
    end else begin
      exp.status = i3c_pkg::STATUS_NACK;
    end
    exp.idx = idx;
    send_cmd(priv_cmd(idx, data), lat);
    take_rsp(hold, got);
    compare_rsp("rsp_o", got, exp);
    if (exp.status == i3c_pkg::STATUS_INVALID) begin
      if (lat != 3) begin
        report_failure($sformatf("Invalid entry answered after %0d cycles instead of 3", lat));
      end
      compare_bit("start_seen", start_cnt != starts, 1'b0);
    end else begin
      exp_frame.dyn_addr = shadow_addr[idx];
      exp_frame.data     = (exp.status == i3c_pkg::STATUS_OK) ? data : 8'h00;
      got_frame.dyn_addr = addr_byte[7:1];
      got_frame.data     = data_bits[8:1];
      compare_frame("frame", got_frame, exp_frame);
      compare_bit("rw_bit", addr_byte[0], 1'b0);
      compare_bit("start_seen", start_cnt == starts + 1, 1'b1);
      compare_bit("stop_seen", stop_cnt == stops + 1, 1'b1);
      compare_bit("sel_od_pp_o", sel_ok, 1'b1);
      if (exp.status == i3c_pkg::STATUS_OK) begin
        compare_bit("t_bit", data_bits[0], odd_parity(data));
      end else begin
        compare_bit("data_bits_seen", rise_cnt != 10, 1'b0);
      end
    end
  endtask

  // Random bytes with the response held back a little longer each time
  task automatic random_held_writes();
    i3c_pkg::dat_idx_t idx;
    logic [7:0]        rnd;
    write_entry(4'd6, 7'h33);
    write_entry(4'd7, 7'h4C);
    for (int i = 0; i < 4; i++) begin
      idx = (i == 0) ? 4'd3 : 4'(4 + i);
      rnd = 8'($urandom());
      private_write(idx, rnd, 2 + i);
    end
  endtask

  initial begin
    reset_i     = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    rsp_ready_i = 1'b1;
    ack_pull    = 1'b0;
    prev_scl    = 1'b1;
    prev_sda    = 1'b1;
    addr_byte   = '0;
    data_bits   = '0;
    ack_low     = 1'b0;
    sel_ok      = 1'b1;
    rise_cnt    = 0;
    start_cnt   = 0;
    stop_cnt    = 0;
    for (int i = 0; i < `I3C_DAT_DEPTH; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_addr[i]  = '0;
    end
    void'($urandom(22));
    repeat (10) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    step();
    check_reset_state();
    write_entry(4'd3, 7'h2A);
    private_write(4'd3, 8'hA5, 0);
    // Nobody answers at 0x11
    write_entry(4'd5, 7'h11);
    private_write(4'd5, 8'h3C, 0);
    private_write(4'd9, 8'h77, 0);
    random_held_writes();
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
logic/i3c_pkg.sv
logic/i3c_dat_mem.sv
logic/i3c_scl_timer.sv
logic/i3c_bit_shifter.sv
logic/i3c_ctrl_fsm.sv
logic/i3c_wrapper.sv
tb/i3c_wrapper_properties.sv
tb/i3c_wrapper_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module i3c_wrapper_tb \
  -Mdir obj_dir -o i3c_sim

./obj_dir/i3c_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi
